// File: hdl/pe_pkg.sv
// Shared widths, opcode enums and bus/operand structs for the PE core, imported by every RTL block
package pe_pkg;

    // Widths fixed by the instruction format
    localparam int DATA_W  = 32;
    localparam int TA_W    = 6;    // Target address and instruction counter
    localparam int IMMLO_W = 6;
    localparam int IMMHI_W = 26;   // Carried by the I prefix
    localparam int OFFS_W  = 10;   // Store offset

    typedef enum logic [2:0] {
        OP_ALU      = 3'b000,
        OP_LOAD     = 3'b001,
        OP_STORE    = 3'b010,
        OP_PREFIX_I = 3'b100,
        OP_CTRL     = 3'b101
    } opclass_e;

    typedef enum logic [3:0] {
        ALU_OR, ALU_AND, ALU_XOR, ALU_ADD, ALU_SUB,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_fn_e;

    // Stores use B, H and W only
    typedef enum logic [3:0] {
        MEM_B  = 4'd1,
        MEM_H  = 4'd2,
        MEM_W  = 4'd3,
        MEM_BU = 4'd4,
        MEM_HU = 4'd5
    } mem_fn_e;

    typedef enum logic [3:0] {
        CTRL_TERM = 4'd4
    } ctrl_fn_e;

    typedef enum logic [1:0] {
        TT_BZ  = 2'b00,   // Branch on zero
        TT_BNZ = 2'b01,   // Branch unless zero
        TT_WRA = 2'b10,   // Write operand A of target
        TT_WRB = 2'b11    // Write operand B of target
    } tt_e;

    typedef struct packed {
        opclass_e             op;
        logic [3:0]           funct;   // ALU, memory or control function
        logic                 immab;   // Immediate goes to B when set
        logic [IMMLO_W-1:0]   immlo;
        logic [IMMHI_W-1:0]   immhi;
        logic [OFFS_W-1:0]    offset;
        logic [TA_W-1:0]      ta1;
        tt_e                  tt1;
        logic [TA_W-1:0]      ta2;
        tt_e                  tt2;
    } instr_t;

    typedef struct packed {
        tt_e                tt;
        logic [DATA_W-1:0]  value;
    } fwd_t;

    typedef struct packed {
        logic               valid;
        logic [TA_W-1:0]    ta;
        tt_e                tt;
    } target_t;

    typedef struct packed {
        logic [DATA_W-1:0]  op_a;
        logic [DATA_W-1:0]  op_b;
    } operands_t;

    typedef struct packed {
        logic               cyc;
        logic               stb;
        logic               we;
        logic [DATA_W-1:0]  adr;
        logic [DATA_W-1:0]  dat;
        logic [3:0]         sel;
    } wb_req_t;

    typedef struct packed {
        logic               ack;
        logic [DATA_W-1:0]  dat;
    } wb_rsp_t;

endpackage

// File: hdl/operand_stage.sv
// Operand register of the PE core, holds the I prefix and builds operands A and B on accept
`timescale 1ns/1ps

module operand_stage
    import pe_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       accept_i,   // Instruction taken this cycle
    input  instr_t     instr_i,
    input  fwd_t       fwd1_i,     // Higher priority forward
    input  fwd_t       fwd2_i,
    output operands_t  opnd_o
);

    logic                  prefix_q;   // Last accepted instruction was an I prefix
    logic [IMMHI_W-1:0]    immhi_q;
    logic [DATA_W-1:0]     imm;
    logic [DATA_W-1:0]     imm_a;
    logic [DATA_W-1:0]     imm_b;
    logic                  is_prefix;

    assign is_prefix = (instr_i.op == OP_PREFIX_I);

    // Widened immediate only right after a prefix
    assign imm   = prefix_q ? {immhi_q, instr_i.immlo}
                            : {{(DATA_W-IMMLO_W){1'b0}}, instr_i.immlo};
    assign imm_a = instr_i.immab ? '0 : imm;
    assign imm_b = instr_i.immab ? imm : '0;

    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
        begin
            prefix_q <= 1'b0;
        end
        else if (accept_i)
        begin
            prefix_q <= is_prefix;   // Any other instruction consumes it
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept_i)
        begin
            immhi_q <= is_prefix ? instr_i.immhi : '0;
            if (!is_prefix)
            begin
                // fwd1 wins over fwd2, then the immediate
                opnd_o.op_a <= (fwd1_i.tt == TT_WRA) ? fwd1_i.value :
                               (fwd2_i.tt == TT_WRA) ? fwd2_i.value : imm_a;
                opnd_o.op_b <= (fwd1_i.tt == TT_WRB) ? fwd1_i.value :
                               (fwd2_i.tt == TT_WRB) ? fwd2_i.value : imm_b;
            end
        end
    end

endmodule

// File: hdl/pe_alu.sv
// Combinational ALU of the PE core, ten functions on operands A and B plus a zero flag for branches
`timescale 1ns/1ps

module pe_alu
    import pe_pkg::*;
(
    input  alu_fn_e            fn_i,
    input  operands_t          opnd_i,
    output logic [DATA_W-1:0]  result_o,
    output logic               zero_o
);

    logic [4:0] shamt;   // Shift amount from B

    assign shamt = opnd_i.op_b[4:0];

    always_comb
    begin
        case (fn_i)
            ALU_OR:   result_o = opnd_i.op_a | opnd_i.op_b;
            ALU_AND:  result_o = opnd_i.op_a & opnd_i.op_b;
            ALU_XOR:  result_o = opnd_i.op_a ^ opnd_i.op_b;
            ALU_ADD:  result_o = opnd_i.op_a + opnd_i.op_b;
            ALU_SUB:  result_o = opnd_i.op_a - opnd_i.op_b;
            ALU_SLT:
            begin
                // Signed compare
                result_o = {{(DATA_W-1){1'b0}},
                            ($signed(opnd_i.op_a) < $signed(opnd_i.op_b))};
            end
            ALU_SLTU:
            begin
                result_o = {{(DATA_W-1){1'b0}}, (opnd_i.op_a < opnd_i.op_b)};
            end
            ALU_SLL:  result_o = opnd_i.op_a << shamt;
            ALU_SRL:  result_o = opnd_i.op_a >> shamt;
            ALU_SRA:  result_o = DATA_W'($signed(opnd_i.op_a) >>> shamt);   // Keeps sign
            default:  result_o = '0;   // Unused codes
        endcase
    end

    assign zero_o = (result_o == '0);

endmodule

// File: hdl/load_store_unit.sv
// Wishbone classic master of the PE core, runs one sized load or store per start pulse
`timescale 1ns/1ps

module load_store_unit
    import pe_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               start_i,    // Begin access, bus cycle opens next edge
    input  logic               we_i,       // Store when high
    input  mem_fn_e            fn_i,
    input  operands_t          opnd_i,
    input  logic [OFFS_W-1:0]  offset_i,
    output wb_req_t            wb_o,
    input  wb_rsp_t            wb_i,
    output logic [DATA_W-1:0]  rdata_o,    // Extended load data
    output logic               done_o
);

    logic               cyc_q;   // Bus cycle open
    logic               we_q;
    mem_fn_e            fn_q;
    logic [DATA_W-1:0]  adr_q;
    logic [DATA_W-1:0]  dat_q;
    logic [3:0]         sel_q;
    logic [DATA_W-1:0]  adr_d;
    logic [DATA_W-1:0]  dat_d;
    logic [3:0]         sel_d;
    logic [DATA_W-1:0]  ext_d;
    logic               launch;
    logic               finish;

    assign launch = start_i && !cyc_q;
    assign finish = cyc_q && wb_i.ack;

    // Loads add A and B, stores add the zero-extended offset to A
    assign adr_d = we_i ? opnd_i.op_a + {{(DATA_W-OFFS_W){1'b0}}, offset_i}
                        : opnd_i.op_a + opnd_i.op_b;

    // Lanes from bit 0 up, store data masked to size
    always_comb
    begin
        case (fn_i)
            MEM_B, MEM_BU:
            begin
                sel_d = 4'b0001;
                dat_d = {24'b0, opnd_i.op_b[7:0]};
            end
            MEM_H, MEM_HU:
            begin
                sel_d = 4'b0011;
                dat_d = {16'b0, opnd_i.op_b[15:0]};
            end
            default:
            begin
                sel_d = 4'b1111;   // Full word
                dat_d = opnd_i.op_b;
            end
        endcase
    end

    always_comb
    begin
        case (fn_q)
            MEM_B:   ext_d = {{24{wb_i.dat[7]}}, wb_i.dat[7:0]};
            MEM_H:   ext_d = {{16{wb_i.dat[15]}}, wb_i.dat[15:0]};
            MEM_BU:  ext_d = {24'b0, wb_i.dat[7:0]};
            MEM_HU:  ext_d = {16'b0, wb_i.dat[15:0]};
            default: ext_d = wb_i.dat;   // lw
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
        begin
            cyc_q  <= 1'b0;
            done_o <= 1'b0;
        end
        else
        begin
            done_o <= finish;   // One-cycle pulse after ack
            if (launch)
                cyc_q <= 1'b1;
            else if (finish)
                cyc_q <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (launch)
        begin
            we_q  <= we_i;
            fn_q  <= fn_i;
            adr_q <= adr_d;
            dat_q <= we_i ? dat_d : '0;
            sel_q <= sel_d;
        end
        if (finish)
            rdata_o <= ext_d;
    end

    // Request fields held stable for the whole cycle
    always_comb
    begin
        wb_o.cyc = cyc_q;
        wb_o.stb = cyc_q;
        wb_o.we  = we_q;
        wb_o.adr = adr_q;
        wb_o.dat = dat_q;
        wb_o.sel = sel_q;
    end

endmodule

// File: hdl/pe_sequencer.sv
// Control FSM of the PE core, accepts one instruction at a time and registers result, targets and counter
`timescale 1ns/1ps

module pe_sequencer
    import pe_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n_i,
    input  instr_t             instr_i,
    input  logic               instr_valid_i,
    output logic               instr_ready_o,
    output logic               accept_o,
    output alu_fn_e            alu_fn_o,      // Held funct, typed for the ALU
    input  logic [DATA_W-1:0]  alu_result_i,
    input  logic               alu_zero_i,
    output logic               mem_start_o,
    output logic               mem_we_o,
    output mem_fn_e            mem_fn_o,      // Held funct, typed for the LSU
    output logic [OFFS_W-1:0]  mem_offset_o,
    input  logic [DATA_W-1:0]  mem_rdata_i,
    input  logic               mem_done_i,
    output logic [DATA_W-1:0]  result_o,
    output target_t            tgt1_o,
    output target_t            tgt2_o,
    output logic               branch_o,
    output logic               term_o,
    output logic               done_o,
    output logic [TA_W-1:0]    icount_o
);

    // S_MEM also covers the single settle cycle of ALU and control ops
    typedef enum logic [1:0] {S_IDLE, S_EXEC, S_MEM} state_e;

    state_e             state_q;
    instr_t             instr_q;   // Instruction in flight
    logic               is_mem;
    logic               finish;
    logic [DATA_W-1:0]  res_d;
    logic               take_d;
    logic               term_d;
    logic               has_tgt;

    assign instr_ready_o = (state_q == S_IDLE);
    assign accept_o      = instr_ready_o && instr_valid_i;
    assign is_mem        = (instr_q.op == OP_LOAD) || (instr_q.op == OP_STORE);
    assign finish        = (state_q == S_MEM) && (!is_mem || mem_done_i);
    assign mem_start_o   = (state_q == S_EXEC) && is_mem;
    assign mem_we_o      = (instr_q.op == OP_STORE);
    assign alu_fn_o      = alu_fn_e'(instr_q.funct);
    assign mem_fn_o      = mem_fn_e'(instr_q.funct);
    assign mem_offset_o  = instr_q.offset;

    // Result, branch decision and terminate per operation class
    always_comb
    begin
        res_d   = '0;   // Stores and control give no result
        take_d  = 1'b0;
        term_d  = 1'b0;
        has_tgt = 1'b0;
        case (instr_q.op)
            OP_ALU:
            begin
                res_d   = alu_result_i;
                has_tgt = 1'b1;
                take_d  = ((instr_q.tt1 == TT_BZ) && alu_zero_i) ||
                          ((instr_q.tt1 == TT_BNZ) && !alu_zero_i);
            end
            OP_LOAD:
            begin
                res_d   = mem_rdata_i;
                has_tgt = 1'b1;
            end
            OP_CTRL:  term_d = (instr_q.funct == CTRL_TERM);
            default:  ;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (accept_o)
            instr_q <= instr_i;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
        begin
            state_q  <= S_IDLE;
            done_o   <= 1'b0;
            branch_o <= 1'b0;
            term_o   <= 1'b0;
            tgt1_o   <= '0;
            tgt2_o   <= '0;
            result_o <= '0;
            icount_o <= '0;
        end
        else
        begin
            done_o <= 1'b0;
            case (state_q)
                S_IDLE:
                begin
                    if (accept_o && (instr_i.op == OP_PREFIX_I))
                        icount_o <= icount_o + 1'b1;   // Prefix stays idle
                    else if (accept_o)
                        state_q <= S_EXEC;
                end
                S_EXEC:  state_q <= S_MEM;
                S_MEM:
                begin
                    if (finish)
                    begin
                        state_q  <= S_IDLE;
                        done_o   <= 1'b1;
                        result_o <= res_d;
                        branch_o <= take_d;
                        term_o   <= term_d;
                        tgt1_o   <= '{valid: has_tgt && (instr_q.tt1 inside {TT_WRA, TT_WRB}),
                                      ta: instr_q.ta1, tt: instr_q.tt1};
                        tgt2_o   <= '{valid: has_tgt && (instr_q.tt2 inside {TT_WRA, TT_WRB}),
                                      ta: instr_q.ta2, tt: instr_q.tt2};
                        if (take_d)
                            icount_o <= instr_q.ta1;
                        else if (!term_d)
                            icount_o <= icount_o + 1'b1;   // Terminate holds
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

endmodule

// File: hdl/pe_core.sv
// Top level of the PE controller, wires operand stage, ALU, Wishbone load/store unit and sequencer
`timescale 1ns/1ps

module pe_core
    import pe_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n_i,
    input  instr_t             instr_i,
    input  logic               instr_valid_i,
    output logic               instr_ready_o,
    input  fwd_t               fwd1_i,
    input  fwd_t               fwd2_i,
    output wb_req_t            wb_o,
    input  wb_rsp_t            wb_i,
    output logic [DATA_W-1:0]  result_o,
    output target_t            tgt1_o,
    output target_t            tgt2_o,
    output logic               branch_o,
    output logic               term_o,
    output logic               done_o,
    output logic [TA_W-1:0]    icount_o
);

    logic               accept;       // Instruction handshake
    operands_t          opnd;
    alu_fn_e            alu_fn;
    logic [DATA_W-1:0]  alu_result;
    logic               alu_zero;
    mem_fn_e            mem_fn;
    logic               mem_start;
    logic               mem_we;
    logic [OFFS_W-1:0]  mem_offset;
    logic [DATA_W-1:0]  mem_rdata;
    logic               mem_done;

    operand_stage u_opnd (
        .clk(clk), .rst_n_i(rst_n_i), .accept_i(accept), .instr_i(instr_i),
        .fwd1_i(fwd1_i), .fwd2_i(fwd2_i), .opnd_o(opnd)
    );

    pe_alu u_alu (
        .fn_i(alu_fn), .opnd_i(opnd), .result_o(alu_result), .zero_o(alu_zero)
    );

    load_store_unit u_lsu (
        .clk(clk), .rst_n_i(rst_n_i), .start_i(mem_start), .we_i(mem_we), .fn_i(mem_fn),
        .opnd_i(opnd), .offset_i(mem_offset), .wb_o(wb_o), .wb_i(wb_i),
        .rdata_o(mem_rdata), .done_o(mem_done)
    );

    pe_sequencer u_seq (
        .clk(clk), .rst_n_i(rst_n_i), .instr_i(instr_i), .instr_valid_i(instr_valid_i),
        .instr_ready_o(instr_ready_o), .accept_o(accept), .alu_fn_o(alu_fn),
        .alu_result_i(alu_result), .alu_zero_i(alu_zero), .mem_start_o(mem_start),
        .mem_we_o(mem_we), .mem_fn_o(mem_fn), .mem_offset_o(mem_offset),
        .mem_rdata_i(mem_rdata), .mem_done_i(mem_done), .result_o(result_o),
        .tgt1_o(tgt1_o), .tgt2_o(tgt2_o), .branch_o(branch_o), .term_o(term_o),
        .done_o(done_o), .icount_o(icount_o)
    );

endmodule

// File: tests/pe_core_asserts.sv
// Bus and handshake assertions that bind into every pe_core instance
`timescale 1ns/1ps

module pe_core_asserts
    import pe_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n_i,
    input  wb_req_t  wb_o,
    input  wb_rsp_t  wb_i,
    input  logic     done_o,
    input  logic     instr_ready_o
);

    // Acked cycle closes on the next edge
    cycle_closes: assert property (@(posedge clk) disable iff (!rst_n_i)
        (wb_o.stb && wb_i.ack) |=> !(wb_o.cyc || wb_o.stb))
        else $error("cyc or stb still high after ack");

    // Classic cycle holds its request until ack
    req_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        (wb_o.stb && !wb_i.ack) |=> (wb_o.stb && $stable(wb_o.adr) && $stable(wb_o.we)
                                     && $stable(wb_o.dat) && $stable(wb_o.sel)))
        else $error("Wishbone request changed before ack");

    done_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        done_o |=> !done_o)
        else $error("done_o high for two cycles");

    busy_not_ready: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_o.cyc |-> !instr_ready_o)
        else $error("instr_ready_o high during a bus cycle");

endmodule

bind pe_core pe_core_asserts u_asserts (
    .clk(clk), .rst_n_i(rst_n_i), .wb_o(wb_o), .wb_i(wb_i),
    .done_o(done_o), .instr_ready_o(instr_ready_o)
);

// File: tests/tb_pe_core.sv
// Directed testbench for pe_core with a 64-word Wishbone memory model and random wait states
`timescale 1ns/1ps

module tb_pe_core
    import pe_pkg::*;
();

    localparam int TIMEOUT = 200;   // Cycles per wait loop

    logic               clk = 1'b0;
    logic               rst_n;
    instr_t             instr;
    logic               valid;
    fwd_t               fwd1;
    fwd_t               fwd2;
    wb_req_t            wb_req;
    wb_rsp_t            wb_rsp;
    logic               instr_ready_o;
    logic [DATA_W-1:0]  result_o;
    target_t            tgt1_o;
    target_t            tgt2_o;
    logic               branch_o;
    logic               term_o;
    logic               done_o;
    logic [TA_W-1:0]    icount_o;

    logic [31:0]        mem [64];   // Word memory, index from adr[7:2]
    logic               model_busy;
    int                 wait_cnt;
    int                 errors;
    int                 test_errs;
    int                 tests_failed;
    string              cur_test;

    pe_core u_dut (
        .clk(clk), .rst_n_i(rst_n), .instr_i(instr), .instr_valid_i(valid),
        .instr_ready_o(instr_ready_o), .fwd1_i(fwd1), .fwd2_i(fwd2), .wb_o(wb_req),
        .wb_i(wb_rsp), .result_o(result_o), .tgt1_o(tgt1_o), .tgt2_o(tgt2_o),
        .branch_o(branch_o), .term_o(term_o), .done_o(done_o), .icount_o(icount_o)
    );

    always #2 clk = ~clk;   // 4 ns period

    // Memory slave, acks after 0 to 3 extra wait cycles
    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            wb_rsp.ack <= 1'b0;
            model_busy = 1'b0;
        end
        else if (wb_rsp.ack)
        begin
            wb_rsp.ack <= 1'b0;   // Master drops cyc on this edge
            model_busy = 1'b0;
        end
        else if (wb_req.cyc && wb_req.stb)
        begin
            if (!model_busy)
            begin
                model_busy = 1'b1;
                wait_cnt = $urandom_range(3, 0);
            end
            if (wait_cnt == 0)
            begin
                wb_rsp.ack <= 1'b1;
                wb_rsp.dat <= mem[wb_req.adr[7:2]];
                for (int k = 0; k < 4; k++)
                begin
                    if (wb_req.we && wb_req.sel[k])
                        mem[wb_req.adr[7:2]][8*k +: 8] <= wb_req.dat[8*k +: 8];
                end
            end
            else
                wait_cnt--;
        end
    end

    function automatic logic [31:0] rnd();
        return $urandom;
    endfunction

    function automatic instr_t make_instr(opclass_e op, logic [3:0] funct);
        instr_t i;
        i       = '0;
        i.op    = op;
        i.funct = funct;
        i.tt1   = TT_WRA;
        i.tt2   = TT_WRA;
        return i;
    endfunction

    function automatic fwd_t make_fwd(tt_e tt, logic [31:0] value);
        fwd_t f;
        f.tt    = tt;
        f.value = value;
        return f;
    endfunction

    // BZ and BNZ on a forward path leave the operands alone
    function automatic fwd_t rand_fwd();
        logic [31:0] r;
        r = rnd();
        return make_fwd(tt_e'(r[1:0]), rnd());
    endfunction

    function automatic operands_t expect_opnds(instr_t ins, fwd_t f1, fwd_t f2,
                                               logic pre, logic [25:0] hi);
        operands_t   o;
        logic [31:0] imm;
        imm    = pre ? {hi, ins.immlo} : {26'b0, ins.immlo};
        o.op_a = ins.immab ? 32'b0 : imm;
        o.op_b = ins.immab ? imm : 32'b0;
        if (f2.tt == TT_WRA)
            o.op_a = f2.value;
        if (f1.tt == TT_WRA)
            o.op_a = f1.value;   // fwd1 overrides fwd2
        if (f2.tt == TT_WRB)
            o.op_b = f2.value;
        if (f1.tt == TT_WRB)
            o.op_b = f1.value;
        return o;
    endfunction

    function automatic logic [31:0] alu_model(int fn, logic [31:0] a, logic [31:0] b);
        logic signed [31:0] sa;
        sa = a;
        case (fn)
            0: return a | b;
            1: return a & b;
            2: return a ^ b;
            3: return a + b;
            4: return a - b;
            5: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            6: return (a < b) ? 32'd1 : 32'd0;
            7: return a << b[4:0];
            8: return a >> b[4:0];
            default: return sa >>> b[4:0];
        endcase
    endfunction

    function automatic logic [31:0] extend_model(mem_fn_e fn, logic [31:0] w);
        case (fn)
            MEM_B:   return {{24{w[7]}}, w[7:0]};
            MEM_H:   return {{16{w[15]}}, w[15:0]};
            MEM_BU:  return {24'b0, w[7:0]};
            MEM_HU:  return {16'b0, w[15:0]};
            default: return w;
        endcase
    endfunction

    task automatic check(string what, logic [31:0] exp, logic [31:0] act);
        if (exp !== act)
        begin
            $display("Error %s %s: expected %h, actual %h", cur_test, what, exp, act);
            errors++;
            test_errs++;
        end
    endtask

    task automatic report_failure(string msg);
        $display("%s: %s", cur_test, msg);
        errors++;
        test_errs++;
    endtask

    task automatic start_test(string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic finish_test();
        if (test_errs == 0)
            $display("%s: passed", cur_test);
        else
        begin
            $display("%s: failed with %0d errors", cur_test, test_errs);
            tests_failed++;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        valid <= 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    // Issue one instruction; edges counts clock edges from acceptance to done_o
    task automatic run_instr(instr_t ins, fwd_t f1, fwd_t f2, logic wait_done,
                             output int edges);
        int t;
        @(posedge clk);
        instr <= ins;
        fwd1  <= f1;
        fwd2  <= f2;
        valid <= 1'b1;
        @(negedge clk);
        t = 0;
        while (!instr_ready_o && t < TIMEOUT)
        begin
            @(negedge clk);
            t++;
        end
        if (!instr_ready_o)
            report_failure("instruction was never accepted");
        @(posedge clk);   // Accept edge
        valid <= 1'b0;
        edges = 0;
        if (wait_done)
        begin
            @(negedge clk);
            while (!done_o && edges < TIMEOUT)
            begin
                @(negedge clk);
                edges++;
            end
            if (!done_o)
                report_failure("done_o never came");
        end
    endtask

    task automatic test_alu();
        instr_t      ins;
        fwd_t        f1;
        fwd_t        f2;
        operands_t   o;
        logic [31:0] r;
        int          edges;
        start_test("alu");
        for (int fn = 0; fn < 10; fn++)
        begin
            for (int n = 0; n < 4; n++)
            begin
                r         = rnd();
                ins       = make_instr(OP_ALU, fn[3:0]);
                ins.immab = r[6];
                ins.immlo = r[5:0];
                f1        = rand_fwd();
                f2        = rand_fwd();
                o         = expect_opnds(ins, f1, f2, 1'b0, 26'b0);
                run_instr(ins, f1, f2, 1'b1, edges);
                check("result", alu_model(fn, o.op_a, o.op_b), result_o);
                check("latency", 32'd2, edges);
            end
        end
        finish_test();
    endtask

    task automatic test_prefix();
        instr_t      ins;
        fwd_t        fb;
        logic [31:0] r;
        logic [25:0] hi;
        logic [5:0]  old_ic;
        int          edges;
        start_test("prefix");
        r         = rnd();
        hi        = r[25:0];
        ins       = make_instr(OP_PREFIX_I, 4'd0);
        ins.immhi = hi;
        old_ic    = icount_o;
        run_instr(ins, make_fwd(TT_BZ, 32'b0), make_fwd(TT_BZ, 32'b0), 1'b0, edges);
        @(negedge clk);
        check("ready", 32'd1, {31'b0, instr_ready_o});
        check("icount", {26'b0, old_ic + 6'd1}, {26'b0, icount_o});
        r         = rnd();
        fb        = make_fwd(TT_WRB, rnd());
        ins       = make_instr(OP_ALU, 4'(ALU_ADD));
        ins.immlo = r[5:0];
        run_instr(ins, make_fwd(TT_BZ, 32'b0), fb, 1'b1, edges);
        check("wide add", {hi, r[5:0]} + fb.value, result_o);
        run_instr(ins, make_fwd(TT_BZ, 32'b0), fb, 1'b1, edges);
        check("narrow add", {26'b0, r[5:0]} + fb.value, result_o);
        finish_test();
    endtask

    task automatic test_branch();
        instr_t      ins;
        logic [31:0] r;
        logic [31:0] x;
        logic [5:0]  old_ic;
        logic        taken;
        int          edges;
        start_test("branch");
        for (int b = 0; b < 4; b++)
        begin
            r       = rnd();
            x       = rnd();
            ins     = make_instr(OP_ALU, 4'(ALU_SUB));
            ins.tt1 = (b < 2) ? TT_BZ : TT_BNZ;
            ins.ta1 = r[5:0];
            taken   = (b < 2) ? (b == 0) : (b == 3);   // b even gives a zero result
            old_ic  = icount_o;
            run_instr(ins, make_fwd(TT_WRA, x),
                      make_fwd(TT_WRB, (b % 2 == 0) ? x : x + 32'd1), 1'b1, edges);
            check("branch_o", {31'b0, taken}, {31'b0, branch_o});
            check("icount", {26'b0, taken ? r[5:0] : old_ic + 6'd1}, {26'b0, icount_o});
            check("tgt1 valid", 32'd0, {31'b0, tgt1_o.valid});
        end
        r       = rnd();
        ins     = make_instr(OP_ALU, 4'(ALU_OR));
        ins.tt2 = TT_WRB;
        ins.ta1 = r[5:0];
        ins.ta2 = r[11:6];
        run_instr(ins, make_fwd(TT_WRA, 32'h10), make_fwd(TT_BZ, 32'b0), 1'b1, edges);
        check("branch_o", 32'd0, {31'b0, branch_o});
        check("tgt1", {23'b0, 1'b1, r[5:0], TT_WRA}, {23'b0, tgt1_o});
        check("tgt2", {23'b0, 1'b1, r[11:6], TT_WRB}, {23'b0, tgt2_o});
        finish_test();
    endtask

    task automatic test_load();
        mem_fn_e     fns [5];
        instr_t      ins;
        logic [31:0] w;
        int          k;
        int          edges;
        fns = '{MEM_B, MEM_H, MEM_W, MEM_BU, MEM_HU};
        start_test("load");
        for (int f = 0; f < 5; f++)
        begin
            for (int s = 0; s < 2; s++)
            begin
                k = f * 2 + s;
                w = s ? (rnd() | 32'h0000_8080) : (rnd() & ~32'h0000_8080);
                mem[8 + k] <= w;
                @(posedge clk);
                ins       = make_instr(OP_LOAD, 4'(fns[f]));
                ins.immab = 1'b1;
                ins.immlo = 6'(4 * k);   // Base 32 on A, word offset on B
                run_instr(ins, make_fwd(TT_WRA, 32'd32), make_fwd(TT_BZ, 32'b0),
                          1'b1, edges);
                check("data", extend_model(fns[f], w), result_o);
                check("tgt1 valid", 32'd1, {31'b0, tgt1_o.valid});
            end
        end
        finish_test();
    endtask

    task automatic test_store();
        mem_fn_e     fns [3];
        logic [31:0] masks [3];
        instr_t      ins;
        logic [31:0] old_w;
        logic [31:0] data;
        logic [5:0]  idx;
        int          edges;
        fns   = '{MEM_B, MEM_H, MEM_W};
        masks = '{32'h0000_00ff, 32'h0000_ffff, 32'hffff_ffff};
        start_test("store");
        for (int f = 0; f < 3; f++)
        begin
            for (int s = 0; s < 2; s++)
            begin
                idx   = 6'(20 + f * 2 + s);
                old_w = rnd();
                data  = rnd();
                mem[idx] <= old_w;
                @(posedge clk);
                ins        = make_instr(OP_STORE, 4'(fns[f]));
                ins.immlo  = 6'd8;   // A from the immediate
                ins.offset = {2'b0, idx - 6'd2, 2'b00};
                run_instr(ins, make_fwd(TT_BZ, 32'b0), make_fwd(TT_WRB, data), 1'b1, edges);
                @(negedge clk);
                check("memory", (old_w & ~masks[f]) | (data & masks[f]), mem[idx]);
                check("result", 32'd0, result_o);
                check("tgt1 valid", 32'd0, {31'b0, tgt1_o.valid});
            end
        end
        finish_test();
    endtask

    task automatic test_term_reset();
        instr_t     ins;
        logic [5:0] old_ic;
        int         t;
        int         edges;
        start_test("terminate and reset");
        old_ic = icount_o;
        ins    = make_instr(OP_CTRL, 4'(CTRL_TERM));
        run_instr(ins, make_fwd(TT_BZ, 32'b0), make_fwd(TT_BZ, 32'b0), 1'b1, edges);
        check("term_o", 32'd1, {31'b0, term_o});
        check("icount", {26'b0, old_ic}, {26'b0, icount_o});
        // Load left in flight, then reset
        ins = make_instr(OP_LOAD, 4'(MEM_W));
        @(posedge clk);
        instr <= ins;
        valid <= 1'b1;
        @(negedge clk);
        t = 0;
        while (!wb_req.cyc && t < TIMEOUT)
        begin
            @(negedge clk);
            t++;
        end
        if (!wb_req.cyc)
            report_failure("load never opened a bus cycle");
        apply_reset();
        @(negedge clk);
        check("done_o", 32'd0, {31'b0, done_o});
        check("branch_o", 32'd0, {31'b0, branch_o});
        check("term_o", 32'd0, {31'b0, term_o});
        check("cyc", 32'd0, {31'b0, wb_req.cyc});
        check("stb", 32'd0, {31'b0, wb_req.stb});
        check("tgt valids", 32'd0, {30'b0, tgt1_o.valid, tgt2_o.valid});
        check("prefix flag", 32'd0, {31'b0, u_dut.u_opnd.prefix_q});
        check("icount", 32'd0, {26'b0, icount_o});
        check("ready", 32'd1, {31'b0, instr_ready_o});
        finish_test();
    endtask

    initial
    begin
        void'($urandom(32'h1055_49ed));
        rst_n        <= 1'b0;
        instr        <= '0;
        valid        <= 1'b0;
        fwd1         <= '0;
        fwd2         <= '0;
        wb_rsp       <= '0;
        model_busy   = 1'b0;
        wait_cnt     = 0;
        errors       = 0;
        tests_failed = 0;
        for (int i = 0; i < 64; i++)
            mem[i] <= 32'hc3c3_0000 | (i << 8) | (~i & 32'h0000_00ff);   // Per-address fill
        apply_reset();
        test_alu();
        test_prefix();
        test_branch();
        test_load();
        test_store();
        test_term_reset();
        $display("Tests run 6, tests failed %0d, errors %0d", tests_failed, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// File: pe_core.f
hdl/pe_pkg.sv
hdl/operand_stage.sv
hdl/pe_alu.sv
hdl/load_store_unit.sv
hdl/pe_sequencer.sv
hdl/pe_core.sv
tests/pe_core_asserts.sv
tests/tb_pe_core.sv

// File: Makefile
VERILATOR := verilator
FLAGS     := --timing --assert
TOP       := tb_pe_core
FILELIST  := pe_core.f
PASS_MSG  := Finished with no errors

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
